// File: isa_pkg.sv
`default_nettype none

// RV32 encoding details the front end needs to spot control flow
package isa_pkg;

    localparam int inst_width = 32;  // base ISA, no compressed forms

    // major opcode sits in the low bits of every RV32 instruction
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;

    // only the control-flow opcodes matter here
    // op_other is a plain op-imm word, any other opcode also classifies as not control flow
    typedef enum logic [opcode_msb-opcode_lsb:0] {
        op_branch = 7'b1100011,  // conditional branch, beq..bgeu
        op_jal    = 7'b1101111,  // pc relative jump
        op_jalr   = 7'b1100111,  // register indirect jump
        op_other  = 7'b0010011   // addi and friends
    } opcode_t;

endpackage

`default_nettype wire

// File: frontend_pkg.sv
`default_nettype none

// sizes and predictor encodings shared by the fetch front end
package frontend_pkg;

    localparam int addr_width = 32;  // rv32 pc

    // defaults for the top level parameters
    localparam int default_fetch_width = 4;   // instructions per cycle
    localparam int default_bht_entries = 64;  // 2-bit counters
    localparam int default_btb_entries = 16;  // direct mapped target entries

    // bimodal counter, upper bit is the prediction
    // weak_not_taken is the reset state so a fresh branch flips after one taken update
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_t;

endpackage

`default_nettype wire

// File: branch_history_table.sv
`timescale 1ns/10ps
`default_nettype none

// bimodal predictor, one 2-bit counter per entry indexed by pc[index_width+1:2]
module branch_history_table
    import frontend_pkg::*;
#(
    parameter int fetch_width = default_fetch_width,
    parameter int bht_entries = default_bht_entries
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [fetch_width-1:0][addr_width-1:0] fetch_pcs,
    input  logic                                   update_valid,
    input  logic [addr_width-1:0]                  update_pc,
    input  logic                                   update_is_branch,
    input  logic                                   update_taken,
    output logic [fetch_width-1:0]                 predict_taken
);

    localparam int index_width = $clog2(bht_entries);

    counter_t               counters [bht_entries];
    logic [index_width-1:0] update_index;
    counter_t               current_count;  // counter being trained
    counter_t               stepped_count;  // its value after the step

    assign update_index = update_pc[index_width+1:2];  // word aligned, drop bits 1:0

    // per slot lookup, all slots read in parallel
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            predict_taken[i] = counters[fetch_pcs[i][index_width+1:2]][1];  // upper half means taken
        end
    end

    // one saturating step toward the resolved direction
    always_comb begin
        current_count = counters[update_index];
        stepped_count = current_count;
        case (current_count)
            strong_not_taken: stepped_count = update_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   stepped_count = update_taken ? weak_taken : strong_not_taken;
            weak_taken:       stepped_count = update_taken ? strong_taken : weak_not_taken;
            strong_taken:     stepped_count = update_taken ? strong_taken : weak_taken;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < bht_entries; e++) begin
                counters[e] <= weak_not_taken;
            end
        end else if (update_valid && update_is_branch) begin
            counters[update_index] <= stepped_count;  // jumps never touch the counters
        end
    end

    // every counter leaves reset known and each step keeps it known,
    // so a lookup from any slot must give a clean prediction
    assert property (@(posedge clock) disable iff (reset)
        !$isunknown(predict_taken))
    else $error("bht: unknown prediction read after reset");

endmodule

`default_nettype wire

// File: branch_target_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// direct mapped btb, index is pc[index_width+1:2], tag is everything above it
module branch_target_buffer
    import frontend_pkg::*;
#(
    parameter int fetch_width = default_fetch_width,
    parameter int btb_entries = default_btb_entries
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [fetch_width-1:0][addr_width-1:0] fetch_pcs,
    input  logic                                   update_valid,
    input  logic [addr_width-1:0]                  update_pc,
    input  logic                                   update_taken,
    input  logic [addr_width-1:0]                  update_target,
    output logic [fetch_width-1:0]                 btb_hit,
    output logic [fetch_width-1:0][addr_width-1:0] btb_target
);

    localparam int index_width = $clog2(btb_entries);
    localparam int tag_width   = addr_width - index_width - 2;

    logic                   valid   [btb_entries];
    logic [tag_width-1:0]   tags    [btb_entries];
    logic [addr_width-1:0]  targets [btb_entries];

    logic [index_width-1:0] update_index;
    logic [tag_width-1:0]   update_tag;
    logic                   install;  // resolved taken transfer, branch or jump

    assign update_index = update_pc[index_width+1:2];
    assign update_tag   = update_pc[addr_width-1:index_width+2];
    assign install      = update_valid && update_taken;

    // parallel tag compare, one comparator per fetch slot
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            btb_hit[i]    = valid[fetch_pcs[i][index_width+1:2]]
                         && (tags[fetch_pcs[i][index_width+1:2]]
                             == fetch_pcs[i][addr_width-1:index_width+2]);
            btb_target[i] = targets[fetch_pcs[i][index_width+1:2]];  // only meaningful on a hit
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < btb_entries; e++) begin
                valid[e] <= 1'b0;
            end
        end else if (install) begin
            valid[update_index] <= 1'b1;
        end
    end

    // tag and target written alongside valid, a conflicting pc simply evicts
    always_ff @(posedge clock) begin
        if (install) begin
            tags[update_index]    <= update_tag;
            targets[update_index] <= update_target;
        end
    end

    // a hit must land on an entry that was installed, so its target is written
    for (genvar i = 0; i < fetch_width; i++) begin : g_hit_check
        assert property (@(posedge clock) disable iff (reset)
            btb_hit[i] |-> !$isunknown(btb_target[i]))
        else $error("btb: slot %0d hit on an entry never installed", i);
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

// pc register plus the per cycle accept and redirect decision
module fetch_unit
    import isa_pkg::*;
    import frontend_pkg::*;
#(
    parameter int fetch_width = default_fetch_width
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [fetch_width-1:0][inst_width-1:0] cache_data,
    input  logic [fetch_width-1:0]                 cache_miss,
    input  logic [$clog2(fetch_width+1)-1:0]       buffer_spots,   // free ibuffer places
    input  logic                                   restore_valid,  // branch stack recovery
    input  logic [addr_width-1:0]                  restore_pc,
    input  logic [fetch_width-1:0]                 predict_taken,
    input  logic [fetch_width-1:0]                 btb_hit,
    input  logic [fetch_width-1:0][addr_width-1:0] btb_target,
    output logic [fetch_width-1:0][addr_width-1:0] fetch_pcs,
    output logic [fetch_width-1:0][inst_width-1:0] fetch_insts,
    output logic [fetch_width-1:0][addr_width-1:0] fetch_inst_pcs,
    output logic [fetch_width-1:0]                 fetch_taken,
    output logic [$clog2(fetch_width+1)-1:0]       fetch_count
);

    localparam int count_width = $clog2(fetch_width+1);

    logic [addr_width-1:0]  pc;
    logic [addr_width-1:0]  next_pc;
    logic [fetch_width-1:0] is_branch;
    logic [fetch_width-1:0] is_jump;     // jal or jalr
    logic [fetch_width-1:0] slot_taken;  // predicted taken if this slot gets accepted
    logic                   stop;        // acceptance ended at an earlier slot

    // consecutive word addresses from the pc register
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            fetch_pcs[i] = pc + addr_width'(4 * i);
        end
    end

    // opcode classify and combine both predictors
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            is_branch[i] = (cache_data[i][opcode_msb:opcode_lsb] == op_branch);
            is_jump[i]   = (cache_data[i][opcode_msb:opcode_lsb] == op_jal)
                        || (cache_data[i][opcode_msb:opcode_lsb] == op_jalr);
            // jumps ignore the counter, but without a btb hit there is no target to go to
            slot_taken[i] = btb_hit[i] && ((is_branch[i] && predict_taken[i]) || is_jump[i]);
        end
    end

    // in order acceptance from slot 0
    always_comb begin
        fetch_insts    = '0;
        fetch_inst_pcs = '0;
        fetch_taken    = '0;
        fetch_count    = '0;
        next_pc        = pc;                     // holds if nothing is accepted
        stop           = reset || restore_valid;  // nothing goes out in these cycles
        for (int i = 0; i < fetch_width; i++) begin
            if ((count_width'(i) >= buffer_spots) || cache_miss[i]) begin
                stop = 1'b1;  // out of space or a miss, the missing slot is refetched
            end
            if (!stop) begin
                fetch_insts[i]    = cache_data[i];
                fetch_inst_pcs[i] = fetch_pcs[i];
                fetch_taken[i]    = slot_taken[i];
                fetch_count       = count_width'(i + 1);
                // redirect on any taken slot so the flag and the next pc agree
                next_pc = slot_taken[i] ? btb_target[i] : fetch_pcs[i] + addr_width'(4);
                stop    = slot_taken[i];  // younger slots are on the wrong path
            end
        end
        if (restore_valid) begin
            next_pc = restore_pc;  // recovery beats any prediction
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;  // program starts at address 0
        end else begin
            pc <= next_pc;
        end
    end

    // count can never pass the slot count, whatever the spots say
    assert property (@(posedge clock) disable iff (reset)
        fetch_count <= count_width'(fetch_width))
    else $error("fetch: count %0d above fetch width", fetch_count);

    // restore cycle sends nothing and fetch resumes at the restore pc
    assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> (fetch_count == '0))
    else $error("fetch: instructions sent in a restore cycle");

    assert property (@(posedge clock) disable iff (reset)
        restore_valid |=> (pc == $past(restore_pc)))
    else $error("fetch: pc did not follow the restore");

endmodule

`default_nettype wire

// File: frontend_top.sv
`timescale 1ns/10ps
`default_nettype none

// fetch unit with its two side by side predictors
module frontend_top
    import isa_pkg::*;
    import frontend_pkg::*;
#(
    parameter int fetch_width = default_fetch_width,
    parameter int bht_entries = default_bht_entries,
    parameter int btb_entries = default_btb_entries
) (
    input  logic                                   clock,
    input  logic                                   reset,
    output logic [fetch_width-1:0][addr_width-1:0] fetch_pcs,      // to the icache
    input  logic [fetch_width-1:0][inst_width-1:0] cache_data,
    input  logic [fetch_width-1:0]                 cache_miss,
    input  logic [$clog2(fetch_width+1)-1:0]       buffer_spots,
    input  logic                                   restore_valid,
    input  logic [addr_width-1:0]                  restore_pc,
    input  logic                                   update_valid,   // resolved branch or jump
    input  logic [addr_width-1:0]                  update_pc,
    input  logic                                   update_is_branch,
    input  logic                                   update_taken,
    input  logic [addr_width-1:0]                  update_target,
    output logic [fetch_width-1:0][inst_width-1:0] fetch_insts,    // to the ibuffer
    output logic [fetch_width-1:0][addr_width-1:0] fetch_inst_pcs,
    output logic [fetch_width-1:0]                 fetch_taken,
    output logic [$clog2(fetch_width+1)-1:0]       fetch_count
);

    logic [fetch_width-1:0]                 predict_taken;
    logic [fetch_width-1:0]                 btb_hit;
    logic [fetch_width-1:0][addr_width-1:0] btb_target;

    fetch_unit #(
        .fetch_width(fetch_width)
    ) u_fetch (
        .clock         (clock),
        .reset         (reset),
        .cache_data    (cache_data),
        .cache_miss    (cache_miss),
        .buffer_spots  (buffer_spots),
        .restore_valid (restore_valid),
        .restore_pc    (restore_pc),
        .predict_taken (predict_taken),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target),
        .fetch_pcs     (fetch_pcs),
        .fetch_insts   (fetch_insts),
        .fetch_inst_pcs(fetch_inst_pcs),
        .fetch_taken   (fetch_taken),
        .fetch_count   (fetch_count)
    );

    // both tables see the same slot pcs the cache sees
    branch_history_table #(
        .fetch_width(fetch_width),
        .bht_entries(bht_entries)
    ) u_bht (
        .clock           (clock),
        .reset           (reset),
        .fetch_pcs       (fetch_pcs),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .update_is_branch(update_is_branch),
        .update_taken    (update_taken),
        .predict_taken   (predict_taken)
    );

    branch_target_buffer #(
        .fetch_width(fetch_width),
        .btb_entries(btb_entries)
    ) u_btb (
        .clock        (clock),
        .reset        (reset),
        .fetch_pcs    (fetch_pcs),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .update_target(update_target),
        .btb_hit      (btb_hit),
        .btb_target   (btb_target)
    );

endmodule

`default_nettype wire

// File: tb_frontend.sv
`timescale 1ns/10ps
`default_nettype none

// fetch front end testbench: icache model, shadow predictor tables, per cycle reference compare
module tb_frontend
    import isa_pkg::*;
    import frontend_pkg::*;
();

    localparam int fetch_width     = 4;
    localparam int bht_entries     = 64;
    localparam int btb_entries     = 16;
    localparam int directed_cycles = 100;  // reset and tests 1 to 5, with slack
    localparam int random_cycles   = 300;
    localparam int watchdog_ns     = (directed_cycles + random_cycles + 50) * 8;

    logic             clock = 1'b0;
    logic             reset = 1'b1;
    logic [2:0]       buffer_spots = '0;
    logic [3:0]       cache_miss = '0;  // miss mask, one bit per slot
    logic             restore_valid = 1'b0;
    logic [31:0]      restore_pc = '0;
    logic             update_valid = 1'b0;
    logic [31:0]      update_pc = '0;
    logic             update_is_branch = 1'b0;
    logic             update_taken = 1'b0;
    logic [31:0]      update_target = '0;
    logic [3:0][31:0] cache_data;
    logic [3:0][31:0] fetch_pcs;
    logic [3:0][31:0] fetch_insts;
    logic [3:0][31:0] fetch_inst_pcs;
    logic [3:0]       fetch_taken;
    logic [2:0]       fetch_count;

    logic [31:0]      prog [256];  // 1 KiB program, higher pcs wrap onto it
    int               shadow_count [64];  // 0 strong nt .. 3 strong taken
    logic             shadow_valid [16];
    logic [25:0]      shadow_tag [16];    // pc[31:6]
    logic [31:0]      shadow_target [16];
    logic [31:0]      expected_pc;
    logic [31:0]      next_pc;
    logic [2:0]       want_count;
    logic [3:0]       want_taken;
    logic [3:0][31:0] want_insts;
    logic [3:0][31:0] want_pcs;
    logic [3:0]       miss_masks [5] = '{4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1010};
    string            test_name = "reset";
    int               checks = 0;
    int               errors = 0;
    int               test_checks = 0;
    int               test_errors = 0;
    int               seed = 32'hfe10_c239;
    logic [31:0]      r;
    logic [31:0]      u;

    always #4 clock = ~clock;  // 8 ns period

    frontend_top #(
        .fetch_width(fetch_width),
        .bht_entries(bht_entries),
        .btb_entries(btb_entries)
    ) DUT (
        .clock           (clock),
        .reset           (reset),
        .fetch_pcs       (fetch_pcs),
        .cache_data      (cache_data),
        .cache_miss      (cache_miss),
        .buffer_spots    (buffer_spots),
        .restore_valid   (restore_valid),
        .restore_pc      (restore_pc),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .update_is_branch(update_is_branch),
        .update_taken    (update_taken),
        .update_target   (update_target),
        .fetch_insts     (fetch_insts),
        .fetch_inst_pcs  (fetch_inst_pcs),
        .fetch_taken     (fetch_taken),
        .fetch_count     (fetch_count)
    );

    // icache model, word per slot straight from the program array
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cache_data[i] = prog[fetch_pcs[i][9:2]];
        end
    end

    task automatic compare_field(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    // expected fetch from the accept rules, returns the next pc
    function automatic logic [31:0] expected_fetch(
        input  logic [31:0]      pc,
        input  logic [2:0]       spots,
        input  logic             restore,
        input  logic [31:0]      restore_to,
        input  logic [3:0]       miss,
        output logic [2:0]       count,
        output logic [3:0]       taken,
        output logic [3:0][31:0] insts,
        output logic [3:0][31:0] pcs
    );
        logic [31:0] next;
        logic [31:0] p;
        logic [31:0] word;
        logic        hit;
        logic        accepting;
        next      = pc;  // nothing accepted, pc holds
        count     = '0;
        taken     = '0;
        insts     = '0;
        pcs       = '0;
        accepting = !restore;
        for (int i = 0; i < 4; i++) begin
            p    = pc + 32'(4 * i);
            word = prog[p[9:2]];
            hit  = shadow_valid[p[5:2]] && (shadow_tag[p[5:2]] == p[31:6]);
            if (i >= int'(spots) || miss[i]) begin
                accepting = 1'b0;
            end
            if (accepting) begin
                insts[i] = word;
                pcs[i]   = p;
                count    = 3'(i + 1);
                taken[i] = hit && ((word[6:0] == op_branch && shadow_count[p[7:2]] >= 2)
                                   || word[6:0] == op_jal || word[6:0] == op_jalr);
                next      = taken[i] ? shadow_target[p[5:2]] : p + 32'd4;
                accepting = !taken[i];  // wrong path after a taken slot
            end
        end
        return restore ? restore_to : next;
    endfunction

    // shadow training, same step rule as the tables
    task automatic train_shadow();
        if (update_is_branch && update_taken && shadow_count[update_pc[7:2]] < 3) begin
            shadow_count[update_pc[7:2]]++;
        end else if (update_is_branch && !update_taken && shadow_count[update_pc[7:2]] > 0) begin
            shadow_count[update_pc[7:2]]--;
        end
        if (update_taken) begin
            shadow_valid[update_pc[5:2]]  = 1'b1;
            shadow_tag[update_pc[5:2]]    = update_pc[31:6];
            shadow_target[update_pc[5:2]] = update_target;
        end
    endtask

    // compare at the falling edge, inputs and outputs are settled there
    always @(negedge clock) begin
        if (reset) begin
            shadow_count = '{default: 1};  // weak not taken
            shadow_valid = '{default: 1'b0};
            expected_pc  = '0;
            compare_field("count in reset", 128'(0), 128'(fetch_count));
        end else begin
            next_pc = expected_fetch(expected_pc, buffer_spots, restore_valid, restore_pc,
                                     cache_miss, want_count, want_taken, want_insts, want_pcs);
            compare_field("pc", 128'(expected_pc), 128'(fetch_pcs[0]));
            compare_field("count", 128'(want_count), 128'(fetch_count));
            compare_field("taken", 128'(want_taken), 128'(fetch_taken));
            compare_field("insts", want_insts, fetch_insts);
            compare_field("inst pcs", want_pcs, fetch_inst_pcs);
            if (update_valid) begin
                train_shadow();  // lands at the coming edge
            end
            expected_pc = next_pc;
        end
    end

    task automatic drive(input int spots, input logic [3:0] miss, input logic restore,
                         input logic [31:0] to, input logic upd, input logic [31:0] upc,
                         input logic is_branch, input logic taken, input logic [31:0] target);
        @(posedge clock);
        buffer_spots     <= 3'(spots);
        cache_miss       <= miss;
        restore_valid    <= restore;
        restore_pc       <= to;
        update_valid     <= upd;
        update_pc        <= upc;
        update_is_branch <= is_branch;
        update_taken     <= taken;
        update_target    <= target;
    endtask

    task automatic step(input int spots, input logic [3:0] miss);
        drive(spots, miss, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test();
        @(negedge clock);
        #1;  // after the last compare
        $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin
        for (int a = 0; a < 256; a++) begin
            prog[a] = {8'(a), ~8'(a), 9'd0, op_other};
        end
        prog[8'h82] = {25'h0, op_branch};  // branch at 0x208
        prog[8'ha1] = {25'h0, op_jal};     // jal at 0x284
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        start_test("sequential");
        repeat (8) step(4, 4'b0000);
        finish_test();

        start_test("spots_miss");
        for (int s = 0; s <= 4; s++) begin
            for (int m = 0; m < 5; m++) begin
                step(s, miss_masks[m]);
            end
        end
        finish_test();

        start_test("restore");
        drive(4, 4'b0000, 1'b1, 32'h100, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        repeat (2) step(4, 4'b0000);
        drive(1, 4'b0000, 1'b1, 32'h3c, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        repeat (2) step(2, 4'b0000);
        finish_test();

        // fall through, then taken after two taken updates, then back after two not taken
        start_test("branch");
        // 0x308 shares the counter of 0x208 but not its btb tag
        repeat (2) drive(0, 4'b0000, 1'b0, 32'h0, 1'b1, 32'h308, 1'b1, 1'b1, 32'h340);
        for (int phase = 0; phase < 3; phase++) begin
            drive(4, 4'b0000, 1'b1, 32'h200, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
            repeat (2) step(4, 4'b0000);
            repeat (2) drive(0, 4'b0000, 1'b0, 32'h0, 1'b1, 32'h208, 1'b1, phase == 0, 32'h300);
        end
        finish_test();

        start_test("jal");
        drive(4, 4'b0000, 1'b1, 32'h280, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        repeat (2) step(4, 4'b0000);
        drive(0, 4'b0000, 1'b0, 32'h0, 1'b1, 32'h284, 1'b0, 1'b1, 32'h120);  // counter untouched
        drive(4, 4'b0000, 1'b1, 32'h280, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
        repeat (2) step(4, 4'b0000);
        finish_test();

        start_test("random");
        @(posedge clock);
        for (int a = 0; a < 256; a++) begin
            r = $random(seed);
            prog[a] <= {r[31:7], (r[2:0] == 3'd0) ? op_branch : (r[2:0] == 3'd1) ? op_jal
                                 : (r[2:0] == 3'd2) ? op_jalr : op_other};
        end
        for (int n = 0; n < random_cycles; n++) begin
            r = $random(seed);
            u = $random(seed);
            drive((r[2:0] > 3'd4) ? 4 : int'(r[2:0]), (r[4:3] == 2'd0) ? r[8:5] : 4'b0000,
                  r[12:9] == 4'd0, {22'd0, r[20:13], 2'b00}, r[23:21] < 3'd3,
                  {22'd0, u[7:0], 2'b00}, u[8], u[9], {22'd0, u[17:10], 2'b00});
        end
        finish_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run still going after %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
isa_pkg.sv
frontend_pkg.sv
branch_history_table.sv
branch_target_buffer.sv
fetch_unit.sv
frontend_top.sv
tb_frontend.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module tb_frontend \
    && ./obj_dir/Vtb_frontend | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
